//--- rtl/rvv_isa_pkg.sv
`default_nettype none

// encodings and field types for the supported rvv subset
package rvv_isa_pkg;

    // raw instruction word and register index
    typedef logic [31:0] insn_t;
    typedef logic [4:0]  vreg_addr_t;

    // major opcodes, bits 6:0
    localparam logic [6:0] OPC_LOAD  = 7'h07;
    localparam logic [6:0] OPC_STORE = 7'h27;
    localparam logic [6:0] OPC_OPV   = 7'h57;

    // funct3 of OP-V, bits 14:12
    localparam logic [2:0] F3_IVV = 3'd0;
    localparam logic [2:0] F3_IVI = 3'd3;
    localparam logic [2:0] F3_CFG = 3'd7;

    // funct6 of integer ops, bits 31:26
    localparam logic [5:0] F6_ADD = 6'h00;
    localparam logic [5:0] F6_SUB = 6'h02;
    localparam logic [5:0] F6_AND = 6'h09;
    localparam logic [5:0] F6_OR  = 6'h0A;
    localparam logic [5:0] F6_XOR = 6'h0B;

    // element width, vsew bits 24:23 of vsetvli
    // vsew bit 2 sits in insn bit 25 and must be zero
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_t;

    // lane operation handed to the alu
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4
    } alu_op_t;

endpackage

`default_nettype wire

//--- rtl/core_cfg_pkg.sv
`default_nettype none

// sizes of the vector core and its memory bus
package core_cfg_pkg;

    // register file geometry
    localparam int VLEN     = 64;
    localparam int NUM_VREG = 32;

    // wishbone classic port
    localparam int WB_DATA_W = 32;
    localparam int WB_ADDR_W = 32;

    // one vector register moves in this many bus beats
    localparam int BEATS_PER_VEC = VLEN / WB_DATA_W;
    // byte spacing of memory slots
    localparam int SLOT_BYTES = 8;

    typedef logic [VLEN-1:0]      vec_t;
    typedef logic [WB_DATA_W-1:0] wb_data_t;
    typedef logic [WB_ADDR_W-1:0] wb_addr_t;

endpackage

`default_nettype wire

//--- rtl/issue_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module issue_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rvv_isa_pkg::insn_t      insn,
    input  logic                    insn_valid,
    output logic                    proc_rdy,
    output rvv_isa_pkg::vreg_addr_t rd_addr_1,
    output rvv_isa_pkg::vreg_addr_t rd_addr_2,
    output rvv_isa_pkg::vreg_addr_t st_addr,
    output logic                    alu_start,
    output rvv_isa_pkg::alu_op_t    alu_op,
    output logic                    use_imm,
    output logic [4:0]              imm,
    output rvv_isa_pkg::sew_t       sew,
    output rvv_isa_pkg::vreg_addr_t alu_dest,
    output logic                    mem_start,
    output logic                    mem_we,
    output logic [4:0]              mem_slot,
    output rvv_isa_pkg::vreg_addr_t mem_vreg,
    input  logic                    mem_done
);
    import rvv_isa_pkg::*;

    // fetch register
    insn_t      insn_q;
    logic       insn_q_valid;

    // decoded fields
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [5:0] funct6;
    logic       is_opv;
    logic       is_alu;
    logic       is_cfg;
    logic       is_mem;
    logic       op_known;

    // one pending alu writeback
    vreg_addr_t inflight_dest;
    logic       inflight_valid;
    logic       hazard;
    logic       mem_busy;

    // field split of the held instruction
    assign opcode    = insn_q[6:0];
    assign funct3    = insn_q[14:12];
    assign funct6    = insn_q[31:26];
    assign rd_addr_1 = insn_q[19:15];
    assign rd_addr_2 = insn_q[24:20];
    // vd of alu and load ops or vs3 of a store
    assign st_addr   = insn_q[11:7];
    assign alu_dest  = insn_q[11:7];
    assign mem_vreg  = insn_q[11:7];
    // rs1 field doubles as immediate and memory slot
    assign imm       = insn_q[19:15];
    assign mem_slot  = insn_q[19:15];

    // funct6 to alu op
    always_comb begin
        op_known = 1'b1;
        case (funct6)
            F6_ADD:  alu_op = ALU_ADD;
            F6_SUB:  alu_op = ALU_SUB;
            F6_AND:  alu_op = ALU_AND;
            F6_OR:   alu_op = ALU_OR;
            F6_XOR:  alu_op = ALU_XOR;
            default: begin
                alu_op   = ALU_ADD;
                op_known = 1'b0;
            end
        endcase
    end

    assign is_opv  = insn_q_valid && (opcode == OPC_OPV);
    assign use_imm = (funct3 == F3_IVI);
    assign is_alu  = is_opv && op_known && ((funct3 == F3_IVV) || use_imm);
    // vsetvli only with vsew bit 2 clear
    assign is_cfg  = is_opv && (funct3 == F3_CFG) && !insn_q[31] && !insn_q[25];
    assign is_mem  = insn_q_valid && ((opcode == OPC_LOAD) || (opcode == OPC_STORE));
    assign mem_we  = (opcode == OPC_STORE);

    // sources still waiting for the alu result
    // memory ops wait on any pending result including the store source
    always_comb begin
        hazard = 1'b0;
        if (inflight_valid) begin
            if (is_alu && !use_imm && (rd_addr_1 == inflight_dest)) begin
                hazard = 1'b1;
            end
            if (is_alu && (rd_addr_2 == inflight_dest)) begin
                hazard = 1'b1;
            end
            if (is_mem) begin
                hazard = 1'b1;
            end
        end
    end

    assign alu_start = is_alu && !hazard;
    assign mem_start = is_mem && !hazard;
    // nothing is taken while stalled or while the bus is in use
    assign proc_rdy  = !(hazard || mem_busy || mem_start);

    always_ff @(posedge clk) begin
        if (proc_rdy) begin
            insn_q <= insn;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            insn_q_valid   <= 1'b0;
            inflight_valid <= 1'b0;
            inflight_dest  <= '0;
            mem_busy       <= 1'b0;
            sew            <= SEW_8;
        end else begin
            // load when ready, hold when stalled, drop once consumed
            if (proc_rdy) begin
                insn_q_valid <= insn_valid;
            end else if (!hazard) begin
                insn_q_valid <= 1'b0;
            end
            // result lands in the regfile one edge after it clears
            inflight_valid <= alu_start;
            if (alu_start) begin
                inflight_dest <= alu_dest;
            end
            if (mem_start) begin
                mem_busy <= 1'b1;
            end else if (mem_done) begin
                mem_busy <= 1'b0;
            end
            if (is_cfg) begin
                sew <= sew_t'(insn_q[24:23]);
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/vec_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module vec_regfile (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rvv_isa_pkg::vreg_addr_t rd_addr_1,
    input  rvv_isa_pkg::vreg_addr_t rd_addr_2,
    input  rvv_isa_pkg::vreg_addr_t st_addr,
    output core_cfg_pkg::vec_t      rd_data_1,
    output core_cfg_pkg::vec_t      rd_data_2,
    output core_cfg_pkg::vec_t      st_data,
    input  logic                    alu_we,
    input  rvv_isa_pkg::vreg_addr_t alu_waddr,
    input  core_cfg_pkg::vec_t      alu_wdata,
    input  logic                    ld_we,
    input  rvv_isa_pkg::vreg_addr_t ld_waddr,
    input  core_cfg_pkg::vec_t      ld_wdata
);
    import core_cfg_pkg::*;

    vec_t regs [NUM_VREG];

    // combinational read ports
    assign rd_data_1 = regs[rd_addr_1];
    assign rd_data_2 = regs[rd_addr_2];
    // store source for the memory sequencer
    assign st_data   = regs[st_addr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_VREG; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // alu writeback
            if (alu_we) begin
                regs[alu_waddr] <= alu_wdata;
            end
            // load writeback
            if (ld_we) begin
                regs[ld_waddr] <= ld_wdata;
            end
        end
    end

    // issue control keeps the two writers apart
    a_one_writer: assert property (@(posedge clk) disable iff (!rst_n)
        !(alu_we && ld_we));

endmodule

`default_nettype wire

//--- rtl/vec_alu.sv
`timescale 1ns/1ns
`default_nettype none

module vec_alu (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  rvv_isa_pkg::alu_op_t    op,
    input  logic                    use_imm,
    input  logic [4:0]              imm,
    input  rvv_isa_pkg::sew_t       sew,
    input  rvv_isa_pkg::vreg_addr_t dest,
    input  core_cfg_pkg::vec_t      vs1_data,
    input  core_cfg_pkg::vec_t      vs2_data,
    output logic                    res_valid,
    output rvv_isa_pkg::vreg_addr_t res_dest,
    output core_cfg_pkg::vec_t      res_data
);
    import rvv_isa_pkg::*;
    import core_cfg_pkg::*;

    vec_t imm_vec;
    vec_t opa;
    vec_t result;

    // add or sub per lane, carries stop at the lane edge
    function automatic vec_t lane_arith(vec_t a, vec_t b, logic sub, sew_t s);
        vec_t r;
        r = '0;
        case (s)
            SEW_8: begin
                for (int i = 0; i < VLEN / 8; i++) begin
                    r[i*8 +: 8] = sub ? b[i*8 +: 8] - a[i*8 +: 8] : b[i*8 +: 8] + a[i*8 +: 8];
                end
            end
            SEW_16: begin
                for (int i = 0; i < VLEN / 16; i++) begin
                    r[i*16 +: 16] = sub ? b[i*16 +: 16] - a[i*16 +: 16]
                                        : b[i*16 +: 16] + a[i*16 +: 16];
                end
            end
            SEW_32: begin
                for (int i = 0; i < VLEN / 32; i++) begin
                    r[i*32 +: 32] = sub ? b[i*32 +: 32] - a[i*32 +: 32]
                                        : b[i*32 +: 32] + a[i*32 +: 32];
                end
            end
            default: r = sub ? b - a : b + a;
        endcase
        return r;
    endfunction

    // simm5 sign extended to sew, copied to every lane
    always_comb begin
        case (sew)
            SEW_8:   imm_vec = {(VLEN / 8){{3{imm[4]}}, imm}};
            SEW_16:  imm_vec = {(VLEN / 16){{11{imm[4]}}, imm}};
            SEW_32:  imm_vec = {(VLEN / 32){{27{imm[4]}}, imm}};
            default: imm_vec = {{(VLEN - 5){imm[4]}}, imm};
        endcase
    end

    assign opa = use_imm ? imm_vec : vs1_data;

    // vs2 op a, bitwise ops ignore sew
    always_comb begin
        case (op)
            ALU_ADD: result = lane_arith(opa, vs2_data, 1'b0, sew);
            ALU_SUB: result = lane_arith(opa, vs2_data, 1'b1, sew);
            ALU_AND: result = vs2_data & opa;
            ALU_OR:  result = vs2_data | opa;
            default: result = vs2_data ^ opa;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= start;
        end
    end

    // result payload
    always_ff @(posedge clk) begin
        if (start) begin
            res_dest <= dest;
            res_data <= result;
        end
    end

endmodule

`default_nettype wire

//--- rtl/mem_seq.sv
`timescale 1ns/1ns
`default_nettype none

module mem_seq (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  logic                     we,
    input  logic [4:0]               slot,
    input  rvv_isa_pkg::vreg_addr_t  vreg,
    input  core_cfg_pkg::vec_t       st_data,
    output logic                     done,
    output logic                     ld_we,
    output rvv_isa_pkg::vreg_addr_t  ld_waddr,
    output core_cfg_pkg::vec_t       ld_wdata,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output core_cfg_pkg::wb_addr_t   wb_adr,
    output core_cfg_pkg::wb_data_t   wb_dat_o,
    output logic [3:0]               wb_sel,
    input  core_cfg_pkg::wb_data_t   wb_dat_i,
    input  logic                     wb_ack
);
    import rvv_isa_pkg::*;
    import core_cfg_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BEAT,
        ST_GAP
    } state_t;

    state_t     state;
    logic       beat;
    logic       in_beat;
    logic       last_beat;

    // request captured at start
    logic       we_q;
    logic [4:0] slot_q;
    vreg_addr_t vreg_q;
    vec_t       st_data_q;
    // first load word waits here for the second
    wb_data_t   lo_word_q;

    assign in_beat   = (state == ST_BEAT);
    assign last_beat = (beat == 1'(BEATS_PER_VEC - 1));

    // bus signals straight from state
    assign wb_cyc   = in_beat;
    assign wb_stb   = in_beat;
    assign wb_we    = in_beat && we_q;
    assign wb_sel   = '1;
    // slot times 8 plus 4 for the high word
    assign wb_adr   = wb_addr_t'(slot_q) * wb_addr_t'(SLOT_BYTES)
                    + wb_addr_t'(beat) * wb_addr_t'(WB_DATA_W / 8);
    assign wb_dat_o = st_data_q[beat*WB_DATA_W +: WB_DATA_W];

    // end of transfer on the last ack
    assign done     = in_beat && wb_ack && last_beat;
    assign ld_we    = done && !we_q;
    assign ld_waddr = vreg_q;
    assign ld_wdata = {wb_dat_i, lo_word_q};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            beat  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= ST_BEAT;
                        beat  <= 1'b0;
                    end
                end
                ST_BEAT: begin
                    // slow ack just keeps us here
                    if (wb_ack) begin
                        state <= last_beat ? ST_IDLE : ST_GAP;
                        beat  <= beat + 1'b1;
                    end
                end
                // one idle bus cycle between beats
                default: state <= ST_BEAT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) begin
            we_q      <= we;
            slot_q    <= slot;
            vreg_q    <= vreg;
            st_data_q <= st_data;
        end
        if (in_beat && wb_ack && !last_beat) begin
            lo_word_q <= wb_dat_i;
        end
    end

    // classic cycle holds the request until ack
    a_stb_held: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we));

endmodule

`default_nettype wire

//--- rtl/vec_core_top.sv
`timescale 1ns/1ns
`default_nettype none

module vec_core_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rvv_isa_pkg::insn_t     insn,
    input  logic                   insn_valid,
    output logic                   proc_rdy,
    output logic                   wb_cyc,
    output logic                   wb_stb,
    output logic                   wb_we,
    output core_cfg_pkg::wb_addr_t wb_adr,
    output core_cfg_pkg::wb_data_t wb_dat_o,
    output logic [3:0]             wb_sel,
    input  core_cfg_pkg::wb_data_t wb_dat_i,
    input  logic                   wb_ack
);
    // issue to regfile and alu
    rvv_isa_pkg::vreg_addr_t rd_addr_1;
    rvv_isa_pkg::vreg_addr_t rd_addr_2;
    rvv_isa_pkg::vreg_addr_t st_addr;
    logic                    alu_start;
    rvv_isa_pkg::alu_op_t    alu_op;
    logic                    use_imm;
    logic [4:0]              imm;
    rvv_isa_pkg::sew_t       sew;
    rvv_isa_pkg::vreg_addr_t alu_dest;

    // issue to memory sequencer
    logic                    mem_start;
    logic                    mem_we;
    logic [4:0]              mem_slot;
    rvv_isa_pkg::vreg_addr_t mem_vreg;
    logic                    mem_done;

    // regfile data paths
    core_cfg_pkg::vec_t      rd_data_1;
    core_cfg_pkg::vec_t      rd_data_2;
    core_cfg_pkg::vec_t      st_data;
    logic                    res_valid;
    rvv_isa_pkg::vreg_addr_t res_dest;
    core_cfg_pkg::vec_t      res_data;
    logic                    ld_we;
    rvv_isa_pkg::vreg_addr_t ld_waddr;
    core_cfg_pkg::vec_t      ld_wdata;

    issue_ctrl u_issue (.clk(clk), .rst_n(rst_n), .insn(insn), .insn_valid(insn_valid),
        .proc_rdy(proc_rdy), .rd_addr_1(rd_addr_1), .rd_addr_2(rd_addr_2), .st_addr(st_addr),
        .alu_start(alu_start), .alu_op(alu_op), .use_imm(use_imm), .imm(imm), .sew(sew),
        .alu_dest(alu_dest), .mem_start(mem_start), .mem_we(mem_we), .mem_slot(mem_slot),
        .mem_vreg(mem_vreg), .mem_done(mem_done));

    vec_regfile u_regfile (.clk(clk), .rst_n(rst_n), .rd_addr_1(rd_addr_1),
        .rd_addr_2(rd_addr_2), .st_addr(st_addr), .rd_data_1(rd_data_1),
        .rd_data_2(rd_data_2), .st_data(st_data), .alu_we(res_valid), .alu_waddr(res_dest),
        .alu_wdata(res_data), .ld_we(ld_we), .ld_waddr(ld_waddr), .ld_wdata(ld_wdata));

    vec_alu u_alu (.clk(clk), .rst_n(rst_n), .start(alu_start), .op(alu_op),
        .use_imm(use_imm), .imm(imm), .sew(sew), .dest(alu_dest), .vs1_data(rd_data_1),
        .vs2_data(rd_data_2), .res_valid(res_valid), .res_dest(res_dest),
        .res_data(res_data));

    mem_seq u_mem (.clk(clk), .rst_n(rst_n), .start(mem_start), .we(mem_we),
        .slot(mem_slot), .vreg(mem_vreg), .st_data(st_data), .done(mem_done),
        .ld_we(ld_we), .ld_waddr(ld_waddr), .ld_wdata(ld_wdata), .wb_cyc(wb_cyc),
        .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_o(wb_dat_o),
        .wb_sel(wb_sel), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack));

endmodule

`default_nettype wire

//--- tb/tb_vec_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_vec_core;
    import rvv_isa_pkg::*;
    import core_cfg_pkg::*;

    // upper bound on instructions issued over all tests
    localparam int INSN_BUDGET = 80;

    logic        clk;
    logic        rst_n;
    insn_t       insn;
    logic        insn_valid;
    logic        proc_rdy;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    wb_addr_t    wb_adr;
    wb_data_t    wb_dat_o;
    logic [3:0]  wb_sel;
    wb_data_t    wb_dat_i;
    logic        wb_ack;

    // wishbone memory, 32 slots of two words
    logic [31:0] mem [64];
    logic [31:0] adr_log [$];
    logic        we_log [$];
    int          ack_count = 0;
    logic [3:0]  delay_seen = '0;
    int          seed = 32'h0c7ce8b3;

    // reference model state
    logic [63:0] exp_reg [32];
    int          exp_sew;

    int          n_checks = 0;
    int          n_err = 0;
    int          err_at_start;
    int          n_issued = 0;
    int          last_wait;

    vec_core_top i_dut (.clk(clk), .rst_n(rst_n), .insn(insn), .insn_valid(insn_valid),
        .proc_rdy(proc_rdy), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_o(wb_dat_o), .wb_sel(wb_sel), .wb_dat_i(wb_dat_i),
        .wb_ack(wb_ack));

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic expect_equal(input string sig, input logic [63:0] got,
                                input logic [63:0] exp);
        n_checks++;
        assert (got === exp) else begin
            $display("Mismatch %s: got %h expected %h", sig, got, exp);
            n_err++;
        end
    endtask

    task automatic require(input bit ok, input string what);
        n_checks++;
        assert (ok) else begin
            $display("%s", what);
            n_err++;
        end
    endtask

    // lane-wise vs2 op a at the given sew, wrapping inside each lane
    function automatic logic [63:0] lane_result(logic [5:0] f6, logic [63:0] a,
                                                logic [63:0] b, int s);
        int          w;
        logic [63:0] mask;
        logic [63:0] x;
        logic [63:0] y;
        logic [63:0] r;
        logic [63:0] acc;
        w = 8 << s;
        mask = (w == 64) ? {64{1'b1}} : ((64'd1 << w) - 64'd1);
        acc = '0;
        for (int lo = 0; lo < 64; lo += w) begin
            x = (b >> lo) & mask;
            y = (a >> lo) & mask;
            case (f6)
                F6_ADD:  r = x + y;
                F6_SUB:  r = x - y;
                F6_AND:  r = x & y;
                F6_OR:   r = x | y;
                default: r = x ^ y;
            endcase
            acc = acc | ((r & mask) << lo);
        end
        return acc;
    endfunction

    // simm5 sign extended, one copy per lane
    function automatic logic [63:0] splat_imm(logic [4:0] imm, int s);
        int          w;
        logic [63:0] ext;
        logic [63:0] mask;
        logic [63:0] acc;
        w = 8 << s;
        ext = {{59{imm[4]}}, imm};
        mask = (w == 64) ? {64{1'b1}} : ((64'd1 << w) - 64'd1);
        acc = '0;
        for (int lo = 0; lo < 64; lo += w) begin
            acc = acc | ((ext & mask) << lo);
        end
        return acc;
    endfunction

    // vm bit set, unmasked
    function automatic insn_t encode_opv(logic [5:0] f6, logic [2:0] f3, int vd, int vs2,
                                         logic [4:0] src1);
        return {f6, 1'b1, 5'(vs2), src1, f3, 5'(vd), OPC_OPV};
    endfunction

    // vsetvli with lmul 1, vsew bit 2 clear
    function automatic insn_t vsetvli_insn(int s);
        return {1'b0, 5'd0, 1'b0, 2'(s), 3'd0, 5'd0, F3_CFG, 5'd0, OPC_OPV};
    endfunction

    // unit stride, rs1 field holds the slot
    function automatic insn_t mem_insn(bit is_store, int vreg, int slot);
        return {3'd0, 1'b0, 2'b00, 1'b1, 5'd0, 5'(slot), 3'b111, 5'(vreg),
                is_store ? OPC_STORE : OPC_LOAD};
    endfunction

    // proc_rdy only depends on state, so the negedge value holds at the next edge
    task automatic issue(input insn_t word);
        int n;
        n = 0;
        insn = word;
        insn_valid = 1'b1;
        @(negedge clk);
        while (!proc_rdy) begin
            n++;
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        insn_valid = 1'b0;
        insn = '0;
        last_wait = n;
        n_issued++;
    endtask

    task automatic wait_ready(output int cycles);
        cycles = 0;
        @(negedge clk);
        while (!proc_rdy) begin
            cycles++;
            @(negedge clk);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic set_sew(input int s);
        issue(vsetvli_insn(s));
        exp_sew = s;
    endtask

    task automatic vop(input logic [5:0] f6, input bit imm_form, input int vd,
                       input int vs2, input int src1);
        logic [63:0] opa;
        opa = imm_form ? splat_imm(5'(src1), exp_sew) : exp_reg[src1];
        issue(encode_opv(f6, imm_form ? F3_IVI : F3_IVV, vd, vs2, 5'(src1)));
        exp_reg[vd] = lane_result(f6, opa, exp_reg[vs2], exp_sew);
    endtask

    // one load or store, checked beat by beat against the slot rule
    task automatic mem_xfer(input bit is_store, input int vreg, input int slot);
        int acks_before;
        int busy;
        adr_log.delete();
        we_log.delete();
        acks_before = ack_count;
        issue(mem_insn(is_store, vreg, slot));
        wait_ready(busy);
        require(busy > 0, "proc_rdy did not drop during the memory transfer");
        require(ack_count == acks_before + 2, "proc_rdy rose before the second ack");
        require(adr_log.size() == 2, "transfer did not run exactly two bus beats");
        if (adr_log.size() == 2) begin
            expect_equal("wb_adr", adr_log[0], 64'(slot * SLOT_BYTES));
            expect_equal("wb_adr", adr_log[1], 64'(slot * SLOT_BYTES + 4));
            expect_equal("wb_we", we_log[0], is_store);
            expect_equal("wb_we", we_log[1], is_store);
        end
        if (is_store) begin
            expect_equal("wb_dat_o", mem[2 * slot], exp_reg[vreg][31:0]);
            expect_equal("wb_dat_o", mem[2 * slot + 1], exp_reg[vreg][63:32]);
        end else begin
            exp_reg[vreg] = {mem[2 * slot + 1], mem[2 * slot]};
        end
    endtask

    task automatic open_test();
        err_at_start = n_err;
    endtask

    task automatic close_test(input string name);
        $display("test %s finished with %0d errors", name, n_err - err_at_start);
    endtask

    // memory model, ack after 0 to 3 wait cycles
    initial begin
        int         wait_left;
        logic [5:0] idx;
        wb_ack = 1'b0;
        wb_dat_i = '0;
        wait_left = -1;
        for (int i = 0; i < 64; i++) begin
            mem[i] = 32'hc3a5_0000 + i * 32'h0104_0411;
        end
        forever begin
            @(posedge clk);
            #2;
            if (wb_ack) begin
                // dut saw the ack at this edge
                wb_ack = 1'b0;
            end else if (wb_cyc && wb_stb) begin
                if (wait_left < 0) begin
                    wait_left = $unsigned($random(seed)) % 4;
                    delay_seen[wait_left] = 1'b1;
                end
                if (wait_left == 0) begin
                    idx = wb_adr[7:2];
                    adr_log.push_back(wb_adr);
                    we_log.push_back(wb_we);
                    expect_equal("wb_sel", wb_sel, 64'hf);
                    if (wb_we) begin
                        mem[idx] = wb_dat_o;
                    end else begin
                        wb_dat_i = mem[idx];
                    end
                    wb_ack = 1'b1;
                    ack_count++;
                    wait_left = -1;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    // classic cycle rules on the bus
    stb_held: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we)
            && $stable(wb_dat_o))
        else begin
            $display("bus request dropped or changed before ack at %0t", $time);
            n_err++;
        end

    stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc)
        else begin
            $display("stb high without cyc at %0t", $time);
            n_err++;
        end

    gap_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb && wb_ack |=> !wb_cyc)
        else begin
            $display("cyc did not drop after an ack at %0t", $time);
            n_err++;
        end

    initial begin
        repeat (4 + 200 * INSN_BUDGET) @(posedge clk);
        $display("timeout after %0d instructions issued", n_issued);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        int slot;
        rst_n = 1'b0;
        insn = '0;
        insn_valid = 1'b0;
        exp_sew = 0;
        for (int i = 0; i < 32; i++) begin
            exp_reg[i] = '0;
        end
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;

        open_test();
        expect_equal("wb_cyc", wb_cyc, 0);
        expect_equal("wb_stb", wb_stb, 0);
        expect_equal("proc_rdy", proc_rdy, 1);
        mem_xfer(1'b1, 5, 2);
        close_test("reset_state");

        // immediate forms, v8 accumulates across sew
        open_test();
        for (int s = 0; s < 4; s++) begin
            set_sew(s);
            vop(F6_ADD, 1'b1, 8, 8, -3);
            vop(F6_OR, 1'b1, 9, 8, 12);
            vop(F6_XOR, 1'b1, 10, 9, -16);
            mem_xfer(1'b1, 8, 3);
            mem_xfer(1'b1, 9, 4);
            mem_xfer(1'b1, 10, 5);
        end
        close_test("vector_immediate");

        // vsub reads v11 and vand reads v12 straight after they issue
        open_test();
        for (int s = 0; s < 4; s++) begin
            set_sew(s);
            vop(F6_ADD, 1'b0, 11, 8, 8);
            vop(F6_SUB, 1'b0, 12, 11, 10);
            vop(F6_AND, 1'b0, 13, 12, 9);
            require(last_wait > 0, "proc_rdy did not drop for the register hazard");
            mem_xfer(1'b1, 12, 6);
            mem_xfer(1'b1, 13, 7);
        end
        close_test("dependent_vv");

        open_test();
        mem[60] = $random(seed);
        mem[61] = $random(seed);
        mem_xfer(1'b0, 14, 30);
        mem_xfer(1'b1, 14, 31);
        close_test("load_store_round_trip");

        open_test();
        for (int k = 0; k < 6; k++) begin
            slot = 16 + $unsigned($random(seed)) % 12;
            mem_xfer(1'b1, 8 + k, slot);
        end
        mem_xfer(1'b0, 20, slot);
        mem_xfer(1'b1, 20, 28);
        require(delay_seen == 4'b1111, "not every ack delay from 0 to 3 was used");
        close_test("bus_backpressure");

        // unknown funct6, then unknown opcode, aimed at v7
        open_test();
        vop(F6_ADD, 1'b1, 7, 7, 5);
        issue(encode_opv(6'h3f, F3_IVV, 7, 8, 9));
        issue({20'd0, 5'd7, 7'h7f});
        mem_xfer(1'b1, 7, 29);
        close_test("unknown_insn");

        $display("checks: %0d, errors: %0d", n_checks, n_err);
        if (n_err == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
rtl/rvv_isa_pkg.sv
rtl/core_cfg_pkg.sv
rtl/issue_ctrl.sv
rtl/vec_regfile.sv
rtl/vec_alu.sv
rtl/mem_seq.sv
rtl/vec_core_top.sv
tb/tb_vec_core.sv
